//--- rtl/sched_pkg.sv
`default_nettype none

package sched_pkg;

    // address field widths, bank group and bank on top
    localparam int BG_BITS  = 1;
    localparam int BA_BITS  = 1;
    localparam int ROW_BITS = 8;
    localparam int COL_BITS = 4;

    localparam int NUM_BANKS  = (2 ** BG_BITS) * (2 ** BA_BITS);
    localparam int BANK_BITS  = BG_BITS + BA_BITS;
    localparam int PADDR_BITS = BG_BITS + BA_BITS + ROW_BITS + COL_BITS;
    localparam int DADDR_BITS = 17; // dram address pins

    // opcode field of the column view
    localparam logic [2:0] OP_WRITE = 3'b110;
    localparam logic [2:0] OP_READ  = 3'b111;
    localparam logic [2:0] OP_PRE   = 3'b101;

    typedef enum logic [1:0] {
        CMD_READ  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_ACT   = 2'd2,
        CMD_PRE   = 2'd3
    } cmd_e;

    // decoded request as held in the queue
    typedef struct packed {
        logic [BG_BITS-1:0]  bank_group;
        logic [BA_BITS-1:0]  bank;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        logic                write;
    } req_t;

    // one address word, read as a row for activate or as opcode + column otherwise
    typedef union packed {
        struct packed {
            logic [DADDR_BITS-ROW_BITS-1:0] pad;
            logic [ROW_BITS-1:0]            row;
        } row_view;
        struct packed {
            logic [2:0]                       opcode;
            logic [DADDR_BITS-3-COL_BITS-1:0] pad;
            logic [COL_BITS-1:0]              col;
        } col_view;
    } dram_addr_u;

endpackage

`default_nettype wire

//--- rtl/sched_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// head of the request queue, consumed by the issuer
interface head_if import sched_pkg::*; ();
    logic head_valid;
    req_t head;
    logic head_pop; // read or write issued for the head

    modport queue (
        output head_valid,
        output head,
        input  head_pop
    );

    modport issuer (
        input  head_valid,
        input  head,
        output head_pop
    );
endinterface

// bank state out of the tracker, update strobes back in
interface bank_if import sched_pkg::*; ();
    logic [NUM_BANKS-1:0]               bank_open;
    logic [NUM_BANKS-1:0]               bank_busy;
    logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_row;

    logic                upd_act;
    logic                upd_pre;
    logic [BANK_BITS-1:0] upd_bank;
    logic [ROW_BITS-1:0] upd_row;

    modport tracker (
        output bank_open, bank_busy, open_row,
        input  upd_act, upd_pre, upd_bank, upd_row
    );

    modport issuer (
        input  bank_open, bank_busy, open_row,
        output upd_act, upd_pre, upd_bank, upd_row
    );
endinterface

`default_nettype wire

//--- rtl/request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module request_queue import sched_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [PADDR_BITS-1:0] req_addr,
    output logic                  req_ready,
    head_if.queue                 head
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    req_t             mem [QUEUE_DEPTH];
    req_t             new_req;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // bank group, bank, row, column from the top bits down
    assign new_req.bank_group = req_addr[PADDR_BITS-1 -: BG_BITS];
    assign new_req.bank       = req_addr[PADDR_BITS-BG_BITS-1 -: BA_BITS];
    assign new_req.row        = req_addr[COL_BITS +: ROW_BITS];
    assign new_req.col        = req_addr[COL_BITS-1:0];
    assign new_req.write      = req_write;

    assign req_ready = (count != CNT_W'(QUEUE_DEPTH)); // low only when full
    assign push      = req_valid && req_ready;
    assign pop       = head.head_pop && head.head_valid;

    assign head.head_valid = (count != '0);
    assign head.head       = mem[rd_ptr];

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0; // depth need not be a power of two
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= new_req;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/bank_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module bank_tracker import sched_pkg::*; #(
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic   clk_in,
    input  logic   rst_in,
    bank_if.tracker banks
);

    localparam int LAT_MAX  = (ACT_LATENCY > PRE_LATENCY) ? ACT_LATENCY : PRE_LATENCY;
    localparam int TMR_BITS = $clog2(LAT_MAX + 1);

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic                open_q;
        logic [ROW_BITS-1:0] row_q;
        logic [TMR_BITS-1:0] timer_q;
        logic                sel;
        logic                hit_act;
        logic                hit_pre;

        assign sel     = (banks.upd_bank == BANK_BITS'(b));
        assign hit_act = banks.upd_act && sel;
        assign hit_pre = banks.upd_pre && sel;

        // timer loads the latency and counts down to zero
        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                open_q  <= 1'b0;
                timer_q <= '0;
            end else if (hit_act) begin
                open_q  <= 1'b1;
                timer_q <= TMR_BITS'(ACT_LATENCY);
            end else if (hit_pre) begin
                open_q  <= 1'b0; // closed once precharged
                timer_q <= TMR_BITS'(PRE_LATENCY);
            end else if (timer_q != '0) begin
                timer_q <= timer_q - 1'b1;
            end
        end

        // row only means something while open_q is set
        always_ff @(posedge clk_in) begin
            if (hit_act) begin
                row_q <= banks.upd_row;
            end
        end

        assign banks.bank_open[b] = open_q;
        assign banks.bank_busy[b] = (timer_q != '0);
        assign banks.open_row[b]  = row_q;
    end

endmodule

`default_nettype wire

//--- rtl/cmd_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_issuer import sched_pkg::*; (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  cmd_ready,
    head_if.issuer                head,
    bank_if.issuer                banks,
    output logic                  cmd_valid,
    output cmd_e                  cmd_op,
    output logic [BG_BITS-1:0]    cmd_bank_group,
    output logic [BA_BITS-1:0]    cmd_bank,
    output logic [DADDR_BITS-1:0] cmd_addr
);

    logic [BANK_BITS-1:0] bank_idx;
    logic                 is_open;
    logic                 row_match;
    logic                 can_issue;
    cmd_e                 next_op;
    dram_addr_u           next_addr;

    assign bank_idx  = {head.head.bank_group, head.head.bank};
    assign is_open   = banks.bank_open[bank_idx];
    assign row_match = (banks.open_row[bank_idx] == head.head.row);

    // one slot per edge, only while the controller takes commands
    assign can_issue = cmd_ready && head.head_valid && !banks.bank_busy[bank_idx];

    always_comb begin
        if (!is_open) begin
            next_op = CMD_ACT;
        end else if (!row_match) begin
            next_op = CMD_PRE; // row conflict
        end else if (head.head.write) begin
            next_op = CMD_WRITE;
        end else begin
            next_op = CMD_READ;
        end
    end

    always_comb begin
        next_addr = '0;
        case (next_op)
            CMD_ACT: next_addr.row_view.row = head.head.row;
            CMD_PRE: begin
                next_addr.col_view.opcode = OP_PRE;
                next_addr.col_view.col    = head.head.col;
            end
            CMD_WRITE: begin
                next_addr.col_view.opcode = OP_WRITE;
                next_addr.col_view.col    = head.head.col;
            end
            default: begin
                next_addr.col_view.opcode = OP_READ;
                next_addr.col_view.col    = head.head.col;
            end
        endcase
    end

    // tracker updates land on the same edge as the command register
    assign banks.upd_act  = can_issue && (next_op == CMD_ACT);
    assign banks.upd_pre  = can_issue && (next_op == CMD_PRE);
    assign banks.upd_bank = bank_idx;
    assign banks.upd_row  = head.head.row;

    assign head.head_pop = can_issue && (next_op == CMD_READ || next_op == CMD_WRITE);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= can_issue; // single cycle pulse
        end
    end

    always_ff @(posedge clk_in) begin
        if (can_issue) begin
            cmd_op         <= next_op;
            cmd_bank_group <= head.head.bank_group;
            cmd_bank       <= head.head.bank;
            cmd_addr       <= next_addr;
        end
    end

endmodule

`default_nettype wire

//--- rtl/request_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module request_scheduler import sched_pkg::*; #(
    parameter int QUEUE_DEPTH = 8,
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [PADDR_BITS-1:0] req_addr,
    output logic                  req_ready,
    input  logic                  cmd_ready,
    output logic                  cmd_valid,
    output cmd_e                  cmd_op,
    output logic [BG_BITS-1:0]    cmd_bank_group,
    output logic [BA_BITS-1:0]    cmd_bank,
    output logic [DADDR_BITS-1:0] cmd_addr
);

    head_if u_head_if ();
    bank_if u_bank_if ();

    request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_ready (req_ready),
        .head      (u_head_if.queue)
    );

    bank_tracker #(
        .ACT_LATENCY (ACT_LATENCY),
        .PRE_LATENCY (PRE_LATENCY)
    ) u_tracker (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .banks  (u_bank_if.tracker)
    );

    cmd_issuer u_issuer (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cmd_ready      (cmd_ready),
        .head           (u_head_if.issuer),
        .banks          (u_bank_if.issuer),
        .cmd_valid      (cmd_valid),
        .cmd_op         (cmd_op),
        .cmd_bank_group (cmd_bank_group),
        .cmd_bank       (cmd_bank),
        .cmd_addr       (cmd_addr)
    );

endmodule

`default_nettype wire

//--- verif/sched_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sched_chk import sched_pkg::*; #(
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               cmd_ready,
    input  logic               cmd_valid,
    input  cmd_e               cmd_op,
    input  logic [BG_BITS-1:0] cmd_bank_group,
    input  logic [BA_BITS-1:0] cmd_bank
);

    int unsigned          fail_count = 0;
    logic [BANK_BITS-1:0] cmd_idx;
    logic [7:0]           gap_q [NUM_BANKS]; // cycles since last act or pre
    logic                 last_act_q [NUM_BANKS];
    logic [7:0]           cur_gap;
    logic                 cur_act;

    assign cmd_idx = {cmd_bank_group, cmd_bank};
    assign cur_gap = gap_q[cmd_idx];
    assign cur_act = last_act_q[cmd_idx];

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                gap_q[b]      <= 8'hff;
                last_act_q[b] <= 1'b0;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (cmd_valid && cmd_idx == BANK_BITS'(b)
                    && (cmd_op == CMD_ACT || cmd_op == CMD_PRE)) begin
                    gap_q[b]      <= 8'd1;
                    last_act_q[b] <= (cmd_op == CMD_ACT);
                end else if (gap_q[b] != 8'hff) begin
                    gap_q[b] <= gap_q[b] + 8'd1; // saturates
                end
            end
        end
    end

    a_valid_after_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        cmd_valid |-> $past(cmd_ready))
        else begin
            fail_count++;
            $error("cmd_valid high without cmd_ready at the previous edge");
        end

    a_act_gap: assert property (@(posedge clk_in) disable iff (rst_in)
        (cmd_valid && cur_act) |-> (cur_gap >= 8'(ACT_LATENCY)))
        else begin
            fail_count++;
            $error("command to bank %0d too soon after its activate", cmd_idx);
        end

    a_pre_gap: assert property (@(posedge clk_in) disable iff (rst_in)
        (cmd_valid && !cur_act) |-> (cur_gap >= 8'(PRE_LATENCY)))
        else begin
            fail_count++;
            $error("command to bank %0d too soon after its precharge", cmd_idx);
        end

endmodule

bind request_scheduler sched_chk #(
    .ACT_LATENCY (ACT_LATENCY),
    .PRE_LATENCY (PRE_LATENCY)
) u_chk (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .cmd_ready      (cmd_ready),
    .cmd_valid      (cmd_valid),
    .cmd_op         (cmd_op),
    .cmd_bank_group (cmd_bank_group),
    .cmd_bank       (cmd_bank)
);

`default_nettype wire

//--- verif/sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sched_tb import sched_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 500;
    localparam int EXP_W          = 2 + BANK_BITS + DADDR_BITS; // op, bank, address

    logic                  clk_in;
    logic                  rst_in;
    logic                  req_valid;
    logic                  req_write;
    logic [PADDR_BITS-1:0] req_addr;
    logic                  req_ready;
    logic                  cmd_ready;
    logic                  cmd_valid;
    cmd_e                  cmd_op;
    logic [BG_BITS-1:0]    cmd_bank_group;
    logic [BA_BITS-1:0]    cmd_bank;
    logic [DADDR_BITS-1:0] cmd_addr;

    logic [EXP_W-1:0]    exp_q [$];
    logic                model_open [NUM_BANKS];
    logic [ROW_BITS-1:0] model_row [NUM_BANKS];
    string               cur_test = "reset";
    int                  errors = 0;
    int                  timeouts = 0;
    event                abort_ev;

    request_scheduler u_dut (
        .clk_in (clk_in), .rst_in (rst_in),
        .req_valid (req_valid), .req_write (req_write), .req_addr (req_addr),
        .req_ready (req_ready), .cmd_ready (cmd_ready), .cmd_valid (cmd_valid),
        .cmd_op (cmd_op), .cmd_bank_group (cmd_bank_group), .cmd_bank (cmd_bank),
        .cmd_addr (cmd_addr)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic finish_run();
        int unsigned chk_errors;
        chk_errors = u_dut.u_chk.fail_count;
        $display("errors: %0d check, %0d assertion, %0d timeout", errors, chk_errors, timeouts);
        if (errors == 0 && chk_errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // a timeout in any wait ends the run here
    initial begin
        @(abort_ev);
        finish_run();
    end

    // expected commands follow the open-row state in request order
    task automatic expect_request(input logic write, input logic [BANK_BITS-1:0] b,
                                  input logic [ROW_BITS-1:0] row, input logic [COL_BITS-1:0] col);
        logic [DADDR_BITS-1:0] col_word;
        col_word = {(write ? 3'b110 : 3'b111), {(DADDR_BITS-3-COL_BITS){1'b0}}, col};
        if (model_open[b] && model_row[b] != row) begin
            exp_q.push_back({CMD_PRE, b, 3'b101, {(DADDR_BITS-3-COL_BITS){1'b0}}, col});
            model_open[b] = 1'b0;
        end
        if (!model_open[b]) begin
            exp_q.push_back({CMD_ACT, b, {(DADDR_BITS-ROW_BITS){1'b0}}, row});
            model_open[b] = 1'b1;
            model_row[b]  = row;
        end
        exp_q.push_back({(write ? CMD_WRITE : CMD_READ), b, col_word});
    endtask

    task automatic send_request(input logic write, input logic [BANK_BITS-1:0] b,
                                input logic [ROW_BITS-1:0] row, input logic [COL_BITS-1:0] col);
        int waited;
        waited = 0;
        while (!req_ready) begin
            @(posedge clk_in);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                timeouts++;
                $display("timeout in %s: req_ready never came back", cur_test);
                -> abort_ev;
            end
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr  = {b, row, col};
        expect_request(write, b, row, col);
        @(posedge clk_in); // accepted here
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_in);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                timeouts++;
                $display("timeout in %s: %0d commands never issued", cur_test, exp_q.size());
                -> abort_ev;
            end
        end
    endtask

    task automatic check_command();
        logic [EXP_W-1:0] expected;
        logic [EXP_W-1:0] actual;
        actual = {cmd_op, cmd_bank_group, cmd_bank, cmd_addr};
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("%s: command %h issued while none was expected", cur_test, actual);
        end
        if (exp_q.size() != 0) begin
            expected = exp_q.pop_front();
            assert (actual == expected) else begin
                errors++;
                $display("FAIL %s expected %h actual %h", cur_test, expected, actual);
            end
        end
    endtask

    always @(negedge clk_in) begin
        if (!rst_in && cmd_valid) begin
            check_command(); // outputs settled mid-cycle
        end
    end

    initial begin
        rst_in    = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        cmd_ready = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            model_open[b] = 1'b0;
            model_row[b]  = '0;
        end
        repeat (8) @(posedge clk_in);
        #1;
        rst_in    = 1'b0;
        cmd_ready = 1'b1;

        cur_test = "idle";
        repeat (10) @(posedge clk_in);
        #1;
        assert (req_ready) else begin
            errors++;
            $display("FAIL %s expected %b actual %b", cur_test, 1'b1, req_ready);
        end

        cur_test = "read_closed";
        send_request(1'b0, 2'd0, 8'h12, 4'h3);
        wait_drain();

        cur_test = "write_conflict";
        send_request(1'b1, 2'd0, 8'h34, 4'h5);
        wait_drain();

        cur_test = "read_hit";
        send_request(1'b0, 2'd0, 8'h34, 4'h9);
        wait_drain();

        cur_test = "backpressure";
        cmd_ready = 1'b0;
        send_request(1'b0, 2'd1, 8'h05, 4'h1);
        send_request(1'b1, 2'd1, 8'h05, 4'h2);
        send_request(1'b0, 2'd2, 8'h07, 4'h3);
        send_request(1'b1, 2'd0, 8'h34, 4'h4); // row hit from earlier
        send_request(1'b0, 2'd3, 8'h01, 4'h5);
        send_request(1'b1, 2'd1, 8'h06, 4'h6);
        send_request(1'b1, 2'd2, 8'h07, 4'h7);
        send_request(1'b0, 2'd0, 8'h11, 4'h8);
        assert (!req_ready) else begin
            errors++;
            $display("FAIL %s expected %b actual %b", cur_test, 1'b0, req_ready);
        end
        repeat (4) @(posedge clk_in);
        #1;
        cmd_ready = 1'b1;
        wait_drain();
        repeat (4) @(posedge clk_in);

        finish_run();
    end

endmodule

`default_nettype wire

//--- list.f
rtl/sched_pkg.sv
rtl/sched_ifs.sv
rtl/request_queue.sv
rtl/bank_tracker.sv
rtl/cmd_issuer.sv
rtl/request_scheduler.sv
verif/sched_chk.sv
verif/sched_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the scheduler testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module sched_tb -Mdir obj_dir -o sched_tb
./obj_dir/sched_tb +verilator+error+limit+100 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run finished"
